// File: common/uart_pkg.sv
// *********************************************************************
// shared types for the serial link: data byte, bit index and the
// transmit and receive state encodings.
// *********************************************************************

package uart_pkg;

	// one data byte on the line.
	typedef logic [7:0] uart_byte_t;

	// index of a data bit within a frame, lsb first.
	typedef logic [2:0] bit_count_t;

	// transmit frame states.
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,	// line high, waiting for a start strobe.
		TX_START = 2'd1,	// start bit on the line.
		TX_DATA  = 2'd2,	// eight data bits, lsb first.
		TX_STOP  = 2'd3	// stop bit on the line.
	} tx_state_t;

	// receive frame states.
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,	// waiting for a falling edge.
		RX_START = 2'd1,	// confirming the start bit at mid-bit.
		RX_DATA  = 2'd2,	// taking eight mid-bit samples.
		RX_STOP  = 2'd3	// judging the stop bit.
	} rx_state_t;

endpackage

// File: hdl/baud_timer.sv
// *********************************************************************
// restartable bit-period counter with half-bit and full-bit ticks.
// *********************************************************************

`timescale 1ns/1ps

module baud_timer #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_restart,
	output logic o_half_tick,
	output logic o_bit_tick
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	// terminal counts for the two ticks.
	localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);

	logic [CW-1:0] count;

	// a restart puts the count back at the start of a bit period.
	always_ff @(posedge clk) begin
		if (i_reset || i_restart) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;	// wrap, ticks keep repeating.
		end else begin
			count <= count + 1'b1;
		end
	end

	// half tick lands mid-bit, bit tick at the end of the period.
	assign o_half_tick = (count == HALF);
	assign o_bit_tick  = (count == LAST);

endmodule

// File: hdl/uart_link_top.sv
// *********************************************************************
// serial link top: transmit and receive paths, each with its own timer.
// *********************************************************************

`timescale 1ns/1ps

module uart_link_top #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                 clk,
	input  logic                 i_reset,
	// transmit side.
	input  logic                 i_tx_start,
	input  uart_pkg::uart_byte_t i_tx_data,
	output logic                 o_tx_busy,
	output logic                 o_tx_line,
	// receive side.
	input  logic                 i_rx_line,
	output uart_pkg::uart_byte_t o_rx_data,
	output logic                 o_rx_valid,
	output logic                 o_rx_frame_err
);

	logic tx_timer_restart;
	logic tx_bit_tick;
	logic tx_load;
	logic tx_shift;

	logic rx_timer_restart;
	logic rx_half_tick;
	logic rx_bit_tick;
	logic rx_line_sync;
	logic rx_sample;

	// *****************************************************************
	// transmit path
	// *****************************************************************
	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_timer (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_restart   (tx_timer_restart),
		.o_half_tick (),	// only bit boundaries matter on transmit.
		.o_bit_tick  (tx_bit_tick)
	);

	tx_sequencer u_tx_sequencer (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_start         (i_tx_start),
		.i_bit_tick      (tx_bit_tick),
		.o_timer_restart (tx_timer_restart),
		.o_load          (tx_load),
		.o_shift         (tx_shift),
		.o_busy          (o_tx_busy)
	);

	tx_shift_reg u_tx_shift_reg (
		.clk     (clk),
		.i_reset (i_reset),
		.i_load  (tx_load),
		.i_shift (tx_shift),
		.i_data  (i_tx_data),
		.o_line  (o_tx_line)
	);

	// *****************************************************************
	// receive path
	// *****************************************************************
	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx_timer (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_restart   (rx_timer_restart),
		.o_half_tick (rx_half_tick),
		.o_bit_tick  (rx_bit_tick)
	);

	rx_sampler u_rx_sampler (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_line      (i_rx_line),
		.i_sample    (rx_sample),
		.o_line_sync (rx_line_sync),
		.o_data      (o_rx_data)
	);

	rx_sequencer u_rx_sequencer (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_line_sync     (rx_line_sync),
		.i_half_tick     (rx_half_tick),
		.i_bit_tick      (rx_bit_tick),
		.o_timer_restart (rx_timer_restart),
		.o_sample        (rx_sample),
		.o_valid         (o_rx_valid),
		.o_frame_err     (o_rx_frame_err)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the uart_link testbench with verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module uart_link_tb -f uart_link.f

./obj_dir/Vuart_link_tb > sim.log 2>&1
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: testbench/tb_clock.sv
// *********************************************************************
// testbench clock source, free running from time zero.
// *********************************************************************

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

endmodule

// File: testbench/uart_link_golden.txt
# columns: mode, byte (hex), expected data (hex), expected valid, expected frame error
# modes: loop = tx wired to rx, bad_stop = low stop bit, glitch = short pulse then a good frame
loop 55 55 1 0
loop aa aa 1 0
loop 00 00 1 0
loop ff ff 1 0
loop 01 01 1 0
loop 80 80 1 0
loop 3c 3c 1 0
loop c3 c3 1 0
loop 7e 7e 1 0
bad_stop a5 a5 0 1
loop 12 12 1 0
bad_stop 00 00 0 1
bad_stop ff ff 0 1
loop 34 34 1 0
glitch 69 69 1 0
glitch 96 96 1 0
loop 0f 0f 1 0
bad_stop 81 81 0 1
glitch f0 f0 1 0
loop e7 e7 1 0
loop 18 18 1 0

// File: testbench/uart_link_tb.sv
// *********************************************************************
// serial link testbench with golden vectors, the tx to rx crossover,
// driven fault frames and the pass or fail summary.
// *********************************************************************

`timescale 1ns/1ps

module uart_link_tb;

	localparam int CLKS_PER_BIT = 16;
	localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
	localparam int PULSE_LIMIT  = 12 * CLKS_PER_BIT;	// longest wait for rx.

	logic       clk;
	logic       i_reset;
	logic       i_tx_start;
	logic [7:0] i_tx_data;
	logic       o_tx_busy;
	logic       o_tx_line;
	logic       i_rx_line;
	logic [7:0] o_rx_data;
	logic       o_rx_valid;
	logic       o_rx_frame_err;

	logic loop_mode;	// high selects the crossover.
	logic drive_line;
	int   errors;
	int   checks;
	int   valid_seen;
	int   err_seen;

	tb_clock #(.PERIOD_NS(100)) u_clock (.o_clk(clk));

	// crossover from the transmit line back into the receiver.
	assign i_rx_line = loop_mode ? o_tx_line : drive_line;

	uart_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) uut (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_tx_start     (i_tx_start),
		.i_tx_data      (i_tx_data),
		.o_tx_busy      (o_tx_busy),
		.o_tx_line      (o_tx_line),
		.i_rx_line      (i_rx_line),
		.o_rx_data      (o_rx_data),
		.o_rx_valid     (o_rx_valid),
		.o_rx_frame_err (o_rx_frame_err)
	);

	// *****************************************************************
	// helpers
	// *****************************************************************
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
		end
	endtask

	// one clock, then count any receive pulse at a settled point.
	task automatic next_cycle();
		@(posedge clk);
		#5;
		if (o_rx_valid === 1'b1) valid_seen++;
		if (o_rx_frame_err === 1'b1) err_seen++;
	endtask

	task automatic wait_for_pulse(input string what);
		int waited;
		waited = 0;
		while (valid_seen == 0 && err_seen == 0 && waited < PULSE_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (valid_seen == 0 && err_seen == 0) begin
			errors++;
			$display("timeout: receiver gave no valid or error pulse for a %s frame", what);
		end
	endtask

	task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
		drive_line = 1'b0;	// start bit.
		repeat (CLKS_PER_BIT) next_cycle();
		for (int i = 0; i < 8; i++) begin
			drive_line = data[i];
			repeat (CLKS_PER_BIT) next_cycle();
		end
		drive_line = stop_bit;
		repeat (CLKS_PER_BIT) next_cycle();
		drive_line = 1'b1;
	endtask

	task automatic check_result(input logic [7:0] exp_data, input logic exp_valid,
			input logic exp_err);
		check_value("o_rx_valid", 32'(exp_valid), valid_seen);
		check_value("o_rx_frame_err", 32'(exp_err), err_seen);
		check_value("o_rx_data", 32'(exp_data), 32'(o_rx_data));
	endtask

	// *****************************************************************
	// frame tests
	// *****************************************************************
	task automatic loop_frame(input logic [7:0] data, input logic [7:0] exp_data,
			input logic exp_valid, input logic exp_err);
		int busy_cycles;
		int late_busy;
		busy_cycles = 0;
		late_busy   = 0;
		valid_seen  = 0;
		err_seen    = 0;
		loop_mode   = 1'b1;
		i_tx_data   = data;
		i_tx_start  = 1'b1;
		next_cycle();
		while (o_tx_busy === 1'b1 && busy_cycles < FRAME_CLKS + 20) begin
			busy_cycles++;
			// a strobe mid-frame with other data has to be dropped.
			i_tx_start = (busy_cycles == 3 * CLKS_PER_BIT);
			if (i_tx_start) i_tx_data = ~data;
			next_cycle();
		end
		i_tx_start = 1'b0;
		if (busy_cycles >= FRAME_CLKS + 20) begin
			errors++;
			$display("timeout: transmitter stayed busy past the end of the frame");
		end
		wait_for_pulse("loopback");
		repeat (2 * CLKS_PER_BIT) begin
			next_cycle();
			if (o_tx_busy !== 1'b0) late_busy++;	// dropped strobe restarted tx.
		end
		check_value("o_tx_busy cycles", FRAME_CLKS, busy_cycles);
		check_value("o_tx_busy after frame", 0, late_busy);
		check_result(exp_data, exp_valid, exp_err);
	endtask

	task automatic driven_frame(input string mode, input logic [7:0] data,
			input logic [7:0] exp_data, input logic exp_valid, input logic exp_err);
		valid_seen = 0;
		err_seen   = 0;
		loop_mode  = 1'b0;
		if (mode == "glitch") begin
			drive_line = 1'b0;
			repeat (4) next_cycle();
			drive_line = 1'b1;
			repeat (PULSE_LIMIT) next_cycle();
			check_value("o_rx_valid after glitch", 0, valid_seen);
			check_value("o_rx_frame_err after glitch", 0, err_seen);
			drive_frame(data, 1'b1);
		end else begin
			drive_frame(data, 1'b0);
		end
		wait_for_pulse(mode);
		repeat (CLKS_PER_BIT) next_cycle();
		check_result(exp_data, exp_valid, exp_err);
	endtask

	// *****************************************************************
	// main sequence
	// *****************************************************************
	initial begin
		string       mode;
		int          fd;
		int          code;
		int          c;
		logic [7:0]  data_v;
		logic [7:0]  exp_data;
		logic        exp_valid;
		logic        exp_err;
		logic [7:0]  rnd;
		errors     = 0;
		checks     = 0;
		valid_seen = 0;
		err_seen   = 0;
		i_reset    = 1'b1;
		i_tx_start = 1'b0;
		i_tx_data  = 8'h00;
		loop_mode  = 1'b1;
		drive_line = 1'b1;
		void'($urandom(74529));
		repeat (8) next_cycle();
		i_reset = 1'b0;
		next_cycle();
		check_value("o_tx_line", 1, 32'(o_tx_line));
		check_value("o_tx_busy", 0, 32'(o_tx_busy));
		check_value("o_rx_valid", 0, 32'(o_rx_valid));
		check_value("o_rx_frame_err", 0, 32'(o_rx_frame_err));
		check_value("o_rx_data", 0, 32'(o_rx_data));

		fd = $fopen("testbench/uart_link_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden vector file");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", mode);
				if (code != 1) break;
				if (mode == "#") begin
					c = $fgetc(fd);	// skip the rest of a comment line.
					while (c != 10 && c != -1) c = $fgetc(fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h", data_v, exp_data, exp_valid, exp_err);
					if (code != 4) begin
						errors++;
						$display("malformed golden line after mode %s", mode);
						break;
					end
					if (mode == "loop") begin
						loop_frame(data_v, exp_data, exp_valid, exp_err);
					end else if (mode == "bad_stop" || mode == "glitch") begin
						driven_frame(mode, data_v, exp_data, exp_valid, exp_err);
					end else begin
						errors++;
						$display("unknown mode %s in golden file", mode);
					end
				end
			end
			$fclose(fd);
		end

		// a few extra loopback bytes.
		for (int i = 0; i < 4; i++) begin
			rnd = 8'($urandom());
			loop_frame(rnd, rnd, 1'b1, 1'b0);
		end

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: uart_link.f
common/uart_pkg.sv
hdl/baud_timer.sv
uart_tx/tx_sequencer.sv
uart_tx/tx_shift_reg.sv
uart_rx/rx_sampler.sv
uart_rx/rx_sequencer.sv
hdl/uart_link_top.sv
testbench/tb_clock.sv
testbench/uart_link_tb.sv

// File: uart_rx/rx_sampler.sv
// *********************************************************************
// receive line synchronizer and the shift-in register for the byte.
// *********************************************************************

`timescale 1ns/1ps

module rx_sampler (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_line,
	input  logic                 i_sample,
	output logic                 o_line_sync,
	output uart_pkg::uart_byte_t o_data
);

	logic line_meta;	// first synchronizer stage.
	logic line_sync;	// second stage, safe to use.
	logic [7:0] shift;

	// *****************************************************************
	// two-flop synchronizer
	// *****************************************************************
	always_ff @(posedge clk) begin
		if (i_reset) begin
			line_meta <= 1'b1;	// idle line level.
			line_sync <= 1'b1;
		end else begin
			line_meta <= i_line;
			line_sync <= line_meta;
		end
	end

	// *****************************************************************
	// shift-in register
	// *****************************************************************
	// data arrives lsb first, so each sample enters at the top and
	// the first bit ends up in bit 0 after eight samples.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			shift <= '0;
		end else if (i_sample) begin
			shift <= {line_sync, shift[7:1]};
		end
	end

	assign o_line_sync = line_sync;
	assign o_data      = shift;	// held until the next frame shifts in.

endmodule

// File: uart_rx/rx_sequencer.sv
// *********************************************************************
// receive FSM: start bit check, mid-bit sample timing, stop bit check
// and the valid and framing error pulses.
// *********************************************************************

`timescale 1ns/1ps

module rx_sequencer (
	input  logic clk,
	input  logic i_reset,
	input  logic i_line_sync,
	input  logic i_half_tick,
	input  logic i_bit_tick,
	output logic o_timer_restart,
	output logic o_sample,
	output logic o_valid,
	output logic o_frame_err
);

	import uart_pkg::*;

	rx_state_t  state;
	bit_count_t bit_idx;
	logic       line_prev;	// line one cycle back, for edge detect.
	logic       fall_edge;
	logic       start_ok;
	logic       valid_q;
	logic       err_q;

	assign fall_edge = line_prev && !i_line_sync;

	// start bit still low at mid-bit.
	assign start_ok = (state == RX_START) && i_half_tick && !i_line_sync;

	// *****************************************************************
	// state register
	// *****************************************************************
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state     <= RX_IDLE;
			bit_idx   <= '0;
			line_prev <= 1'b1;
			valid_q   <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			line_prev <= i_line_sync;
			valid_q   <= 1'b0;
			err_q     <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (fall_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (i_half_tick) begin
						if (start_ok) begin
							state   <= RX_DATA;
							bit_idx <= '0;
						end else begin
							state <= RX_IDLE;	// glitch, no output.
						end
					end
				end
				RX_DATA: begin
					if (i_bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == '1) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (i_bit_tick) begin
						// stop sample decides which pulse goes out.
						valid_q <= i_line_sync;
						err_q   <= !i_line_sync;
						state   <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// *****************************************************************
	// outputs
	// *****************************************************************
	// restart on the edge, then again at mid start bit so that every
	// later bit tick falls in the middle of a bit.
	assign o_timer_restart = ((state == RX_IDLE) && fall_edge) || start_ok;

	assign o_sample    = (state == RX_DATA) && i_bit_tick;
	assign o_valid     = valid_q;
	assign o_frame_err = err_q;

endmodule

// File: uart_tx/tx_sequencer.sv
// *********************************************************************
// transmit FSM: steps a frame through start, data and stop bits.
// *********************************************************************

`timescale 1ns/1ps

module tx_sequencer (
	input  logic clk,
	input  logic i_reset,
	input  logic i_start,
	input  logic i_bit_tick,
	output logic o_timer_restart,
	output logic o_load,
	output logic o_shift,
	output logic o_busy
);

	import uart_pkg::*;

	tx_state_t  state;
	bit_count_t bit_idx;
	logic       accept;

	// a strobe while busy is simply dropped.
	assign accept = (state == TX_IDLE) && i_start;

	// *****************************************************************
	// state register
	// *****************************************************************
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state   <= TX_IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (accept) begin
						state <= TX_START;
					end
				end
				TX_START: begin
					if (i_bit_tick) begin
						state   <= TX_DATA;
						bit_idx <= '0;
					end
				end
				TX_DATA: begin
					if (i_bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == '1) begin	// last data bit done.
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: begin
					if (i_bit_tick) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// *****************************************************************
	// outputs
	// *****************************************************************
	assign o_load          = accept;	// frame register picks up the byte.
	assign o_timer_restart = accept;	// start bit begins next cycle.

	// every bit boundary moves the next bit onto the line.
	assign o_shift = (state != TX_IDLE) && i_bit_tick;

	// busy spans the whole frame, start bit through stop bit.
	assign o_busy = (state != TX_IDLE);

endmodule

// File: uart_tx/tx_shift_reg.sv
// *********************************************************************
// transmit frame register, loads a framed byte and shifts it out.
// *********************************************************************

`timescale 1ns/1ps

module tx_shift_reg (
	input  logic                clk,
	input  logic                i_reset,
	input  logic                i_load,
	input  logic                i_shift,
	input  uart_pkg::uart_byte_t i_data,
	output logic                o_line
);

	// bit 0 is on the line, bit 9 holds the stop bit after a load.
	logic [9:0] frame;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			frame <= '1;	// idle line is high.
		end else if (i_load) begin
			// stop bit, data, start bit.
			frame <= {1'b1, i_data, 1'b0};
		end else if (i_shift) begin
			frame <= {1'b1, frame[9:1]};	// ones fill from the top.
		end
	end

	// the line is the low bit of the frame register.
	assign o_line = frame[0];

endmodule
